/* source/decodePkg.sv */
//--------------------
// shared widths, encodings and bundles for the MIPS decode stage
// referenced by scoped name from the RTL and the testbench
//--------------------
`default_nettype none

package decodePkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // operand source, driven by the hazard unit
    typedef enum logic [1:0] {
        fwdRegFile = 2'd0,
        fwdExe     = 2'd1,
        fwdMem     = 2'd2,
        fwdWb      = 2'd3
    } fwdSelT;

    typedef enum logic [1:0] {
        pcSeq     = 2'd0,
        pcBranch  = 2'd1,
        pcJump    = 2'd2,
        pcJumpReg = 2'd3
    } pcSelT;

    // only equality compares are kept
    typedef enum logic [1:0] {
        brNone = 2'd0,
        brEq   = 2'd1,
        brNe   = 2'd2
    } branchKindT;

    typedef enum logic [2:0] {
        aluNop  = 3'd0,
        aluAdd  = 3'd1,
        aluSub  = 3'd2,
        aluAnd  = 3'd3,
        aluOr   = 3'd4,
        aluLui  = 3'd5,
        aluLink = 3'd6
    } aluOpT;

    typedef enum logic [1:0] {
        srcBReg  = 2'd0,
        srcBSext = 2'd1,
        srcBZext = 2'd2
    } srcBT;

    typedef struct packed {
        aluOpT   aluOp;
        srcBT    srcB;
        logic    regWrite;
        regAddrT destReg;
        logic    reservedInst;
    } ctrlT;

    // ID/EXE bundle, all zeros is a bubble
    typedef struct packed {
        logic valid;
        ctrlT ctrl;
        wordT pc;
        wordT operandA;
        wordT operandB;
        wordT signImm;
        wordT zeroImm;
    } idExeT;

    // standard MIPS encodings
    localparam opcodeT opSpecial = 6'h00;
    localparam opcodeT opJ       = 6'h02;
    localparam opcodeT opJal     = 6'h03;
    localparam opcodeT opBeq     = 6'h04;
    localparam opcodeT opBne     = 6'h05;
    localparam opcodeT opAddiu   = 6'h09;
    localparam opcodeT opOri     = 6'h0d;
    localparam opcodeT opLui     = 6'h0f;

    localparam functT fnJr   = 6'h08;
    localparam functT fnAddu = 6'h21;
    localparam functT fnSubu = 6'h23;
    localparam functT fnAnd  = 6'h24;
    localparam functT fnOr   = 6'h25;

    localparam regAddrT linkReg = 5'd31;

endpackage

`default_nettype wire

/* source/instrDecoder.sv */
//--------------------
// instruction field decode for the ID stage
// produces control, immediates, destination register and the
// pc-relative and absolute jump targets, all combinational
//--------------------
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  wire decodePkg::wordT       inst,
    input  wire decodePkg::wordT       pc,
    output decodePkg::regAddrT         rsAddr,
    output decodePkg::regAddrT         rtAddr,
    output decodePkg::ctrlT            ctrl,
    output decodePkg::branchKindT      branchKind,
    output logic                       isJump,
    output logic                       isJumpReg,
    output decodePkg::wordT            signImm,
    output decodePkg::wordT            zeroImm,
    output decodePkg::wordT            branchTarget,
    output decodePkg::wordT            jumpTarget
);

    decodePkg::opcodeT  opcode;
    decodePkg::functT   funct;
    decodePkg::regAddrT rdAddr;
    decodePkg::wordT    pcPlus4;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rsAddr = inst[25:21];
    assign rtAddr = inst[20:16];
    assign rdAddr = inst[15:11];

    assign signImm = {{16{inst[15]}}, inst[15:0]};
    assign zeroImm = {16'h0000, inst[15:0]};

    assign pcPlus4 = pc + 32'd4;

    // branch offset counts words from the delay slot
    assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], inst[25:0], 2'b00};

    always_comb begin
        ctrl       = '0;
        branchKind = decodePkg::brNone;
        isJump     = 1'b0;
        isJumpReg  = 1'b0;

        case (opcode)
            decodePkg::opSpecial: begin
                // R-type writes rd
                ctrl.srcB     = decodePkg::srcBReg;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rdAddr;
                case (funct)
                    decodePkg::fnAddu: ctrl.aluOp = decodePkg::aluAdd;
                    decodePkg::fnSubu: ctrl.aluOp = decodePkg::aluSub;
                    decodePkg::fnAnd:  ctrl.aluOp = decodePkg::aluAnd;
                    decodePkg::fnOr:   ctrl.aluOp = decodePkg::aluOr;
                    decodePkg::fnJr: begin
                        isJumpReg     = 1'b1;
                        ctrl.regWrite = 1'b0;
                        ctrl.destReg  = '0;
                    end
                    default: begin
                        ctrl.reservedInst = 1'b1;
                        ctrl.regWrite     = 1'b0;
                        ctrl.destReg      = '0;
                    end
                endcase
            end
            decodePkg::opAddiu: begin
                ctrl.aluOp    = decodePkg::aluAdd;
                ctrl.srcB     = decodePkg::srcBSext;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rtAddr;
            end
            decodePkg::opOri: begin
                ctrl.aluOp    = decodePkg::aluOr;
                ctrl.srcB     = decodePkg::srcBZext;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rtAddr;
            end
            decodePkg::opLui: begin
                // upper half comes from the zero-extended immediate
                ctrl.aluOp    = decodePkg::aluLui;
                ctrl.srcB     = decodePkg::srcBZext;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = rtAddr;
            end
            decodePkg::opBeq: branchKind = decodePkg::brEq;
            decodePkg::opBne: branchKind = decodePkg::brNe;
            decodePkg::opJ:   isJump = 1'b1;
            decodePkg::opJal: begin
                isJump        = 1'b1;
                ctrl.aluOp    = decodePkg::aluLink;
                ctrl.regWrite = 1'b1;
                ctrl.destReg  = decodePkg::linkReg;
            end
            default: ctrl.reservedInst = 1'b1;
        endcase
    end

    // at most one kind of control transfer per instruction
    noMixedTransfer: assert final (
        $onehot0({isJump, isJumpReg, branchKind != decodePkg::brNone})
    ) else $error("instrDecoder: more than one control transfer decoded");

endmodule

`default_nettype wire

/* source/operandResolve.sv */
//--------------------
// operand forwarding for the ID stage
// picks each operand from the register file or a later stage,
// then feeds the equality compare and the jr target
//--------------------
`timescale 1ns/1ns
`default_nettype none

module operandResolve (
    input  wire decodePkg::wordT   regData1,
    input  wire decodePkg::wordT   regData2,
    input  wire decodePkg::wordT   exeData,
    input  wire decodePkg::wordT   memData,
    input  wire decodePkg::wordT   wbData,
    input  wire decodePkg::fwdSelT fwdSel1,
    input  wire decodePkg::fwdSelT fwdSel2,
    output decodePkg::wordT        operandA,
    output decodePkg::wordT        operandB,
    output logic                   operandsEqual,
    output decodePkg::wordT        jumpRegTarget
);

    // same four-way choice for both read ports
    function automatic decodePkg::wordT pickSource(
        input decodePkg::fwdSelT sel,
        input decodePkg::wordT   fromRegFile,
        input decodePkg::wordT   fromExe,
        input decodePkg::wordT   fromMem,
        input decodePkg::wordT   fromWb
    );
        decodePkg::wordT chosen;
        case (sel)
            decodePkg::fwdExe: chosen = fromExe;
            decodePkg::fwdMem: chosen = fromMem;
            decodePkg::fwdWb:  chosen = fromWb;
            default:           chosen = fromRegFile;
        endcase
        return chosen;
    endfunction

    assign operandA = pickSource(fwdSel1, regData1, exeData, memData, wbData);
    assign operandB = pickSource(fwdSel2, regData2, exeData, memData, wbData);

    // branch decision uses the forwarded values
    assign operandsEqual = (operandA == operandB);
    assign jumpRegTarget = operandA;

    // hazard unit must always drive a defined select
    selectsKnown: assert final (!$isunknown({fwdSel1, fwdSel2}))
        else $error("operandResolve: forwarding select is unknown");

endmodule

`default_nettype wire

/* source/decodeIssue.sv */
//--------------------
// next-pc choice and the ID/EXE pipeline register
// a stall loads a bubble, the bundle lands one cycle after decode
//--------------------
`timescale 1ns/1ns
`default_nettype none

module decodeIssue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         stall,
    input  wire decodePkg::ctrlT        ctrl,
    input  wire decodePkg::branchKindT  branchKind,
    input  wire                         isJump,
    input  wire                         isJumpReg,
    input  wire                         operandsEqual,
    input  wire decodePkg::wordT        pc,
    input  wire decodePkg::wordT        operandA,
    input  wire decodePkg::wordT        operandB,
    input  wire decodePkg::wordT        signImm,
    input  wire decodePkg::wordT        zeroImm,
    output decodePkg::pcSelT            pcSel,
    output decodePkg::idExeT            idExe
);

    logic            branchTaken;
    decodePkg::idExeT nextBundle;

    assign branchTaken = (branchKind == decodePkg::brEq && operandsEqual)
                      || (branchKind == decodePkg::brNe && !operandsEqual);

    always_comb begin
        if (branchTaken) begin
            pcSel = decodePkg::pcBranch;
        end else if (isJump) begin
            pcSel = decodePkg::pcJump;
        end else if (isJumpReg) begin
            pcSel = decodePkg::pcJumpReg;
        end else begin
            pcSel = decodePkg::pcSeq;
        end
    end

    always_comb begin
        nextBundle.valid    = 1'b1;
        nextBundle.ctrl     = ctrl;
        nextBundle.pc       = pc;
        nextBundle.operandA = operandA;
        nextBundle.operandB = operandB;
        nextBundle.signImm  = signImm;
        nextBundle.zeroImm  = zeroImm;
    end

    // bubble is the all-zero bundle
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            idExe <= '0;
        end else begin
            idExe <= nextBundle;
        end
    end

    // EXE must never retire a write from an empty slot
    bubbleNoWrite: assert property (
        @(posedge clk) !idExe.valid |-> !idExe.ctrl.regWrite
    ) else $error("decodeIssue: register write flagged on an invalid slot");

endmodule

`default_nettype wire

/* source/decodeStage.sv */
//--------------------
// top of the MIPS decode stage
// register file, hazard unit and fetch stay outside,
// idExe feeds the execute stage
//--------------------
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  wire                         clk,
    input  wire                         rst,
    input  wire decodePkg::wordT        inst,
    input  wire decodePkg::wordT        pc,
    input  wire decodePkg::wordT        regData1,
    input  wire decodePkg::wordT        regData2,
    input  wire decodePkg::wordT        exeData,
    input  wire decodePkg::wordT        memData,
    input  wire decodePkg::wordT        wbData,
    input  wire decodePkg::fwdSelT      fwdSel1,
    input  wire decodePkg::fwdSelT      fwdSel2,
    input  wire                         stall,
    output decodePkg::regAddrT          regAddr1,
    output decodePkg::regAddrT          regAddr2,
    output decodePkg::pcSelT            pcSel,
    output decodePkg::wordT             branchTarget,
    output decodePkg::wordT             jumpTarget,
    output decodePkg::wordT             jumpRegTarget,
    output decodePkg::idExeT            idExe
);

    decodePkg::ctrlT       ctrl;
    decodePkg::branchKindT branchKind;
    logic                  isJump;
    logic                  isJumpReg;
    logic                  operandsEqual;
    decodePkg::wordT       signImm;
    decodePkg::wordT       zeroImm;
    decodePkg::wordT       operandA;
    decodePkg::wordT       operandB;

    // rs and rt go straight out as register file read addresses
    instrDecoder decoder (
        .inst         (inst),
        .pc           (pc),
        .rsAddr       (regAddr1),
        .rtAddr       (regAddr2),
        .ctrl         (ctrl),
        .branchKind   (branchKind),
        .isJump       (isJump),
        .isJumpReg    (isJumpReg),
        .signImm      (signImm),
        .zeroImm      (zeroImm),
        .branchTarget (branchTarget),
        .jumpTarget   (jumpTarget)
    );

    operandResolve resolver (
        .regData1      (regData1),
        .regData2      (regData2),
        .exeData       (exeData),
        .memData       (memData),
        .wbData        (wbData),
        .fwdSel1       (fwdSel1),
        .fwdSel2       (fwdSel2),
        .operandA      (operandA),
        .operandB      (operandB),
        .operandsEqual (operandsEqual),
        .jumpRegTarget (jumpRegTarget)
    );

    decodeIssue issue (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .ctrl          (ctrl),
        .branchKind    (branchKind),
        .isJump        (isJump),
        .isJumpReg     (isJumpReg),
        .operandsEqual (operandsEqual),
        .pc            (pc),
        .operandA      (operandA),
        .operandB      (operandB),
        .signImm       (signImm),
        .zeroImm       (zeroImm),
        .pcSel         (pcSel),
        .idExe         (idExe)
    );

endmodule

`default_nettype wire

/* sim/decodeChecker.sv */
//--------------------
// checker for the decode stage testbench
// compares comb outputs each cycle and idExe one cycle later
// against a reference model of the decode rules
//--------------------
`timescale 1ns/1ns
`default_nettype none

module decodeChecker (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire decodePkg::wordT inst,
    input wire decodePkg::wordT pc,
    input wire decodePkg::wordT regData1,
    input wire decodePkg::wordT regData2,
    input wire decodePkg::wordT exeData,
    input wire decodePkg::wordT memData,
    input wire decodePkg::wordT wbData,
    input wire decodePkg::fwdSelT fwdSel1,
    input wire decodePkg::fwdSelT fwdSel2,
    input wire decodePkg::regAddrT regAddr1,
    input wire decodePkg::regAddrT regAddr2,
    input wire decodePkg::pcSelT pcSel,
    input wire decodePkg::wordT branchTarget,
    input wire decodePkg::wordT jumpTarget,
    input wire decodePkg::wordT jumpRegTarget,
    input wire decodePkg::idExeT idExe
);

    localparam int tReset = 0;
    localparam int tAlu = 1;
    localparam int tFwd = 2;
    localparam int tBranch = 3;
    localparam int tStall = 4;

    typedef struct packed {
        decodePkg::idExeT bundle;
        decodePkg::pcSelT pcSel;
        decodePkg::wordT branchTarget;
        decodePkg::wordT jumpTarget;
        decodePkg::wordT jumpRegTarget;
    } refT;

    int passCount [5];
    int failCount [5];
    refT nowRef, prevRef;
    logic havePrev = 1'b0;
    logic prevRst = 1'b1;
    logic prevStall = 1'b0;
    logic stallBefore = 1'b0;
    logic resetDone = 1'b0;

    function automatic string nameOf(input int t);
        case (t)
            tReset: return "reset";
            tAlu: return "aluDecode";
            tFwd: return "forwarding";
            tBranch: return "branchJump";
            default: return "stall";
        endcase
    endfunction

    function automatic decodePkg::wordT sourceFor(input decodePkg::fwdSelT sel,
            input decodePkg::wordT rf, exe, mem, wb);
        if (sel == decodePkg::fwdExe) return exe;
        if (sel == decodePkg::fwdMem) return mem;
        if (sel == decodePkg::fwdWb) return wb;
        return rf;
    endfunction

    function automatic refT expectedBundle(input decodePkg::wordT instW, pcW, rd1, rd2,
            exe, mem, wb, input decodePkg::fwdSelT sel1, sel2);
        refT r;
        decodePkg::aluOpT alu;
        decodePkg::wordT sImm;
        decodePkg::wordT nextPc;
        r = '0;
        alu = decodePkg::aluNop;
        sImm = {{16{instW[15]}}, instW[15:0]};
        nextPc = pcW + 32'd4;
        r.bundle.valid = 1'b1;
        r.bundle.pc = pcW;
        r.bundle.operandA = sourceFor(sel1, rd1, exe, mem, wb);
        r.bundle.operandB = sourceFor(sel2, rd2, exe, mem, wb);
        r.bundle.signImm = sImm;
        r.bundle.zeroImm = {16'h0000, instW[15:0]};
        r.branchTarget = nextPc + (sImm << 2);
        r.jumpTarget = {nextPc[31:28], instW[25:0], 2'b00};
        r.jumpRegTarget = r.bundle.operandA;
        r.pcSel = decodePkg::pcSeq;
        case (instW[31:26])
            decodePkg::opSpecial: begin
                case (instW[5:0])
                    decodePkg::fnAddu: alu = decodePkg::aluAdd;
                    decodePkg::fnSubu: alu = decodePkg::aluSub;
                    decodePkg::fnAnd: alu = decodePkg::aluAnd;
                    decodePkg::fnOr: alu = decodePkg::aluOr;
                    decodePkg::fnJr: r.pcSel = decodePkg::pcJumpReg;
                    default: r.bundle.ctrl.reservedInst = 1'b1;
                endcase
                if (alu != decodePkg::aluNop) begin
                    r.bundle.ctrl.aluOp = alu;
                    r.bundle.ctrl.regWrite = 1'b1;
                    r.bundle.ctrl.destReg = instW[15:11];
                end
            end
            decodePkg::opAddiu, decodePkg::opOri, decodePkg::opLui: begin
                r.bundle.ctrl.regWrite = 1'b1;
                r.bundle.ctrl.destReg = instW[20:16];
                r.bundle.ctrl.srcB = (instW[31:26] == decodePkg::opAddiu) ?
                    decodePkg::srcBSext : decodePkg::srcBZext;
                r.bundle.ctrl.aluOp = (instW[31:26] == decodePkg::opAddiu) ? decodePkg::aluAdd :
                    (instW[31:26] == decodePkg::opOri) ? decodePkg::aluOr : decodePkg::aluLui;
            end
            decodePkg::opBeq: if (r.bundle.operandA == r.bundle.operandB)
                r.pcSel = decodePkg::pcBranch;
            decodePkg::opBne: if (r.bundle.operandA != r.bundle.operandB)
                r.pcSel = decodePkg::pcBranch;
            decodePkg::opJ: r.pcSel = decodePkg::pcJump;
            decodePkg::opJal: begin
                r.pcSel = decodePkg::pcJump;
                r.bundle.ctrl.aluOp = decodePkg::aluLink;
                r.bundle.ctrl.regWrite = 1'b1;
                r.bundle.ctrl.destReg = decodePkg::linkReg;
            end
            default: r.bundle.ctrl.reservedInst = 1'b1;
        endcase
        return r;
    endfunction

    task automatic compareValue(input int t, input string what,
            input logic [191:0] expected, input logic [191:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", nameOf(t), what, expected, actual);
            failCount[t]++;
        end else begin
            passCount[t]++;
        end
    endtask

    always @(negedge clk) begin
        nowRef = expectedBundle(inst, pc, regData1, regData2, exeData, memData, wbData,
            fwdSel1, fwdSel2);
        // idExe holds what was presented one cycle ago
        if (havePrev) begin
            if (prevRst) begin
                compareValue(tReset, "idExe", '0, idExe);
                compareValue(tReset, "valid", 1'b0, idExe.valid);
            end else if (prevStall) begin
                compareValue(tStall, "bubble", '0, idExe);
            end else begin
                compareValue(tAlu, "ctrl", prevRef.bundle.ctrl, idExe.ctrl);
                compareValue(tAlu, "signImm", prevRef.bundle.signImm, idExe.signImm);
                compareValue(tAlu, "zeroImm", prevRef.bundle.zeroImm, idExe.zeroImm);
                compareValue(tAlu, "pc", prevRef.bundle.pc, idExe.pc);
                compareValue(tFwd, "operandA", prevRef.bundle.operandA, idExe.operandA);
                compareValue(tFwd, "operandB", prevRef.bundle.operandB, idExe.operandB);
                if (stallBefore) begin
                    compareValue(tStall, "valid after stall", 1'b1, idExe.valid);
                    compareValue(tStall, "pc after stall", prevRef.bundle.pc, idExe.pc);
                end else begin
                    compareValue(tAlu, "valid", 1'b1, idExe.valid);
                end
            end
        end
        if (!rst) begin
            compareValue(tAlu, "regAddr1", inst[25:21], regAddr1);
            compareValue(tAlu, "regAddr2", inst[20:16], regAddr2);
            compareValue(tBranch, "pcSel", nowRef.pcSel, pcSel);
            compareValue(tBranch, "branchTarget", nowRef.branchTarget, branchTarget);
            compareValue(tBranch, "jumpTarget", nowRef.jumpTarget, jumpTarget);
            compareValue(tBranch, "jumpRegTarget", nowRef.jumpRegTarget, jumpRegTarget);
        end
        // reset window closes once rst has dropped
        if (havePrev && prevRst && !rst && !resetDone) begin
            $display("test %s done: %0d checks, %0d failed", nameOf(tReset),
                passCount[tReset] + failCount[tReset], failCount[tReset]);
            resetDone = 1'b1;
        end
        havePrev = 1'b1;
        stallBefore = prevStall;
        prevStall = stall;
        prevRst = rst;
        prevRef = nowRef;
    end

    task printSummary(output int totalFails);
        int totalPass;
        totalPass = 0;
        totalFails = 0;
        for (int t = tAlu; t <= tStall; t++) begin
            $display("test %s done: %0d checks, %0d failed", nameOf(t),
                passCount[t] + failCount[t], failCount[t]);
        end
        for (int t = tReset; t <= tStall; t++) begin
            if (passCount[t] + failCount[t] == 0) begin
                $display("test %s never ran a single check", nameOf(t));
                totalFails++;
            end
            totalPass += passCount[t];
            totalFails += failCount[t];
        end
        $display("totals: %0d passed, %0d failed", totalPass, totalFails);
    endtask

endmodule

`default_nettype wire

/* sim/decodeStageTb.sv */
//--------------------
// testbench for the MIPS decode stage
// drives random legal and illegal instructions, forwarding
// selects and stalls into the DUT
// decodeChecker compares the responses
//--------------------
`timescale 1ns/1ns
`default_nettype none

module decodeStageTb;

    localparam int resetCycles = 3;
    localparam int numCycles   = 400;
    // stimulus length plus drain cycles and a margin
    localparam int timeoutNs   = (resetCycles + numCycles + 4) * 20 + 500;

    logic clk;
    logic rst;
    logic stall;
    decodePkg::wordT inst, pc;
    decodePkg::wordT regData1, regData2, exeData, memData, wbData;
    decodePkg::fwdSelT fwdSel1, fwdSel2;
    decodePkg::regAddrT regAddr1, regAddr2;
    decodePkg::pcSelT pcSel;
    decodePkg::wordT branchTarget, jumpTarget, jumpRegTarget;
    decodePkg::idExeT idExe;
    integer seed;
    int failTotal;

    decodeStage uut (
        .clk(clk), .rst(rst), .inst(inst), .pc(pc),
        .regData1(regData1), .regData2(regData2),
        .exeData(exeData), .memData(memData), .wbData(wbData),
        .fwdSel1(fwdSel1), .fwdSel2(fwdSel2), .stall(stall),
        .regAddr1(regAddr1), .regAddr2(regAddr2), .pcSel(pcSel),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget),
        .jumpRegTarget(jumpRegTarget), .idExe(idExe)
    );

    decodeChecker checkUnit (
        .clk(clk), .rst(rst), .stall(stall), .inst(inst), .pc(pc),
        .regData1(regData1), .regData2(regData2),
        .exeData(exeData), .memData(memData), .wbData(wbData),
        .fwdSel1(fwdSel1), .fwdSel2(fwdSel2),
        .regAddr1(regAddr1), .regAddr2(regAddr2), .pcSel(pcSel),
        .branchTarget(branchTarget), .jumpTarget(jumpTarget),
        .jumpRegTarget(jumpRegTarget), .idExe(idExe)
    );

    always #10 clk = ~clk;

    // kinds 12 and 13 build illegal encodings
    function automatic decodePkg::wordT randomInst(input int kind, input logic [31:0] bits);
        decodePkg::wordT w;
        case (kind)
            0:  w = {decodePkg::opSpecial, bits[25:11], 5'd0, decodePkg::fnAddu};
            1:  w = {decodePkg::opSpecial, bits[25:11], 5'd0, decodePkg::fnSubu};
            2:  w = {decodePkg::opSpecial, bits[25:11], 5'd0, decodePkg::fnAnd};
            3:  w = {decodePkg::opSpecial, bits[25:11], 5'd0, decodePkg::fnOr};
            4:  w = {decodePkg::opSpecial, bits[25:21], 15'd0, decodePkg::fnJr};
            5:  w = {decodePkg::opAddiu, bits[25:0]};
            6:  w = {decodePkg::opOri, bits[25:0]};
            7:  w = {decodePkg::opLui, bits[25:0]};
            8:  w = {decodePkg::opBeq, bits[25:0]};
            9:  w = {decodePkg::opBne, bits[25:0]};
            10: w = {decodePkg::opJ, bits[25:0]};
            11: w = {decodePkg::opJal, bits[25:0]};
            12: w = {decodePkg::opSpecial, bits[25:6], 6'h3f};
            default: w = {6'h3e, bits[25:0]};
        endcase
        return w;
    endfunction

    task driveRandom;
        int kind;
        logic [31:0] bits;
        logic [31:0] data1;
        logic [1:0] sel1;
        logic shareSrc;
        kind = {$random(seed)} % 14;
        bits = $random(seed);
        data1 = $random(seed);
        sel1 = $random(seed);
        // equal operands now and then so branches get taken
        shareSrc = ({$random(seed)} % 3) == 0;
        inst <= randomInst(kind, bits);
        pc <= {$random(seed)} & 32'hffff_fffc;
        regData1 <= data1;
        regData2 <= shareSrc ? data1 : $random(seed);
        exeData <= $random(seed);
        memData <= $random(seed);
        wbData <= $random(seed);
        fwdSel1 <= decodePkg::fwdSelT'(sel1);
        fwdSel2 <= shareSrc ? decodePkg::fwdSelT'(sel1) : decodePkg::fwdSelT'($random(seed));
        stall <= ({$random(seed)} % 5) == 0;
    endtask

    initial begin
        seed = 95;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        inst = '0;
        pc = '0;
        regData1 = '0;
        regData2 = '0;
        exeData = '0;
        memData = '0;
        wbData = '0;
        fwdSel1 = decodePkg::fwdRegFile;
        fwdSel2 = decodePkg::fwdRegFile;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < numCycles; i++) begin
            driveRandom();
            @(posedge clk);
        end
        // let the last bundle reach idExe and be compared
        repeat (2) @(posedge clk);
        checkUnit.printSummary(failTotal);
        if (failTotal == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("timeout: the stimulus did not complete in the expected time");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* decodeStage.f */
source/decodePkg.sv
source/instrDecoder.sv
source/operandResolve.sv
source/decodeIssue.sv
source/decodeStage.sv
sim/decodeChecker.sv
sim/decodeStageTb.sv
